// ==== design/bus_pkg.sv ====
package bus_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	parameter int TAG_W  = 6;
	parameter int DATA_W = 32;

	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [DATA_W-1:0] word_t;

	////////////////////////////////////////////////////////////
	// requests and beats
	////////////////////////////////////////////////////////////

	// fixed latency unit asking for a slot
	typedef struct packed {
		logic valid;
		tag_t tag;
	} slot_req_t;

	// zero latency path, data comes with the request
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} in_req_t;

	// also used for merged operands
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} cdb_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} rob_read_t;

endpackage

// ==== design/unit_pkg.sv ====
package unit_pkg;

	////////////////////////////////////////////////////////////
	// unit codes, index into the result array of each bus
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		GPR_ADD_SUB,
		GPR_NEXT_MOV,
		GPR_LW,
		GPR_FTOI
	} gpr_unit_t;

	// fdiv and fsqrt request separately
	typedef enum logic [2:0] {
		FPR_FDIV,
		FPR_FSQRT,
		FPR_FADD_FSUB,
		FPR_FMUL,
		FPR_ITOF,
		FPR_LW,
		FPR_FMOV
	} fpr_unit_t;

	parameter int GPR_N_UNIT = 4;
	parameter int FPR_N_UNIT = 7;

	////////////////////////////////////////////////////////////
	// entry stages, bus latency is stage + 1
	////////////////////////////////////////////////////////////

	parameter int GPR_STAGE [GPR_N_UNIT] = '{0, 0, 0, 2};
	parameter int FPR_STAGE [FPR_N_UNIT] = '{13, 13, 5, 3, 2, 0, 0};

	// one past the deepest entry stage
	parameter int GPR_DEPTH = 3;
	parameter int FPR_DEPTH = 14;

endpackage

// ==== design/slot_reserve.sv ====
`timescale 1ns/1ps

module slot_reserve #(
	parameter int DEPTH = 1,
	parameter int N_REQ = 1,
	parameter int STAGE [N_REQ] = '{default: 0},
	parameter type unit_t = logic
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                flush,
	input  bus_pkg::slot_req_t  req [N_REQ],
	output logic [N_REQ-1:0]    ready,
	output logic                head_valid,
	output bus_pkg::tag_t       head_tag,
	output unit_t               head_unit
);

	typedef struct packed {
		bus_pkg::tag_t tag;
		unit_t         unit;
	} slot_t;

	logic [DEPTH-1:0] rsv_valid;
	slot_t            rsv_slot [DEPTH];
	logic [DEPTH-1:0] valid_next;
	slot_t            slot_next [DEPTH];
	logic [N_REQ-1:0] grant;

	////////////////////////////////////////////////////////////
	// ready per requester
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < N_REQ; i++) begin : g_ready
		logic pass_busy;
		logic prio_busy;

		// an entry moving down into our stage wins
		if (STAGE[i] + 1 < DEPTH) begin : g_pass
			assign pass_busy = rsv_valid[STAGE[i] + 1];
		end else begin : g_top
			assign pass_busy = 1'b0;
		end

		// lower code at the same stage wins
		always_comb begin
			prio_busy = 1'b0;
			for (int j = 0; j < i; j++) begin
				if (STAGE[j] == STAGE[i] && req[j].valid) begin
					prio_busy = 1'b1;
				end
			end
		end

		assign ready[i] = !pass_busy && !prio_busy;
		assign grant[i] = req[i].valid && ready[i];
	end

	////////////////////////////////////////////////////////////
	// next state per stage
	////////////////////////////////////////////////////////////

	for (genvar s = 0; s < DEPTH; s++) begin : g_stage
		logic  shift_valid;
		slot_t shift_slot;
		logic  load_valid;
		slot_t load_slot;

		if (s + 1 < DEPTH) begin : g_mid
			assign shift_valid = rsv_valid[s + 1];
			assign shift_slot  = rsv_slot[s + 1];
		end else begin : g_top
			assign shift_valid = 1'b0;
			assign shift_slot  = '0;
		end

		// at most one grant per stage, and only if nothing shifts in
		always_comb begin
			load_valid = shift_valid;
			load_slot  = shift_slot;
			for (int i = 0; i < N_REQ; i++) begin
				if (STAGE[i] == s && grant[i]) begin
					load_valid     = 1'b1;
					load_slot.tag  = req[i].tag;
					load_slot.unit = unit_t'(i);
				end
			end
		end

		assign valid_next[s] = load_valid;
		assign slot_next[s]  = load_slot;
	end

	// flush also drops a grant from the same cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsv_valid <= '0;
		end else if (flush) begin
			rsv_valid <= '0;
		end else begin
			rsv_valid <= valid_next;
		end
	end

	always_ff @(posedge clk) begin
		rsv_slot <= slot_next;
	end

	assign head_valid = rsv_valid[0];
	assign head_tag   = rsv_slot[0].tag;
	assign head_unit  = rsv_slot[0].unit;

endmodule

// ==== design/result_bus.sv ====
`timescale 1ns/1ps

module result_bus #(
	parameter int DEPTH = 1,
	parameter int N_REQ = 1,
	parameter int STAGE [N_REQ] = '{default: 0},
	parameter type unit_t = logic
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                flush,
	input  bus_pkg::slot_req_t  req [N_REQ],
	output logic [N_REQ-1:0]    ready,
	input  bus_pkg::in_req_t    in_req,
	output logic                in_ready,
	input  bus_pkg::word_t      result [N_REQ],
	output bus_pkg::cdb_t       bus
);

	logic          head_valid;
	bus_pkg::tag_t head_tag;
	unit_t         head_unit;
	logic          in_grant;

	slot_reserve #(
		.DEPTH  (DEPTH),
		.N_REQ  (N_REQ),
		.STAGE  (STAGE),
		.unit_t (unit_t)
	) slot (
		.clk,
		.arst_n,
		.flush,
		.req,
		.ready,
		.head_valid,
		.head_tag,
		.head_unit
	);

	////////////////////////////////////////////////////////////
	// bus beat
	////////////////////////////////////////////////////////////

	// input path only fills an empty head, no delay
	assign in_ready = !head_valid;
	assign in_grant = in_req.valid && in_ready;

	always_comb begin
		bus.valid = head_valid || in_grant;
		if (head_valid) begin
			bus.tag  = head_tag;
			// unit result of the cycle the tag shows up
			bus.data = result[head_unit];
		end else begin
			bus.tag  = in_req.tag;
			bus.data = in_req.data;
		end
	end

endmodule

// ==== design/operand_merge.sv ====
`timescale 1ns/1ps

module operand_merge #(
	parameter int N_READ = 2
) (
	input  bus_pkg::cdb_t      arch_read [N_READ],
	input  bus_pkg::rob_read_t rob_read [N_READ],
	input  bus_pkg::cdb_t      bus,
	output bus_pkg::cdb_t      operand [N_READ]
);

	for (genvar i = 0; i < N_READ; i++) begin : g_port
		logic bus_hit;

		// tag being written back right now
		assign bus_hit = bus.valid && bus.tag == arch_read[i].tag;

		assign operand[i].valid = arch_read[i].valid || rob_read[i].valid || bus_hit;
		assign operand[i].tag   = arch_read[i].tag;

		// arch first, then bus, rob last
		always_comb begin
			if (arch_read[i].valid) begin
				operand[i].data = arch_read[i].data;
			end else if (bus_hit) begin
				operand[i].data = bus.data;
			end else begin
				operand[i].data = rob_read[i].data;
			end
		end
	end

endmodule

// ==== design/cdb_top.sv ====
`timescale 1ns/1ps

module cdb_top #(
	parameter int N_READ = 2
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 flush,

	input  bus_pkg::slot_req_t   gpr_req [unit_pkg::GPR_N_UNIT],
	output logic [unit_pkg::GPR_N_UNIT-1:0] gpr_ready,
	input  bus_pkg::in_req_t     gpr_in_req,
	output logic                 gpr_in_ready,
	input  bus_pkg::word_t       gpr_result [unit_pkg::GPR_N_UNIT],
	output bus_pkg::cdb_t        gpr_bus,
	input  bus_pkg::cdb_t        gpr_arch_read [N_READ],
	input  bus_pkg::rob_read_t   gpr_rob_read [N_READ],
	output bus_pkg::cdb_t        gpr_operand [N_READ],

	input  bus_pkg::slot_req_t   fpr_req [unit_pkg::FPR_N_UNIT],
	output logic [unit_pkg::FPR_N_UNIT-1:0] fpr_ready,
	input  bus_pkg::in_req_t     fpr_in_req,
	output logic                 fpr_in_ready,
	input  bus_pkg::word_t       fpr_result [unit_pkg::FPR_N_UNIT],
	output bus_pkg::cdb_t        fpr_bus,
	input  bus_pkg::cdb_t        fpr_arch_read [N_READ],
	input  bus_pkg::rob_read_t   fpr_rob_read [N_READ],
	output bus_pkg::cdb_t        fpr_operand [N_READ]
);

	////////////////////////////////////////////////////////////
	// gpr
	////////////////////////////////////////////////////////////

	result_bus #(
		.DEPTH  (unit_pkg::GPR_DEPTH),
		.N_REQ  (unit_pkg::GPR_N_UNIT),
		.STAGE  (unit_pkg::GPR_STAGE),
		.unit_t (unit_pkg::gpr_unit_t)
	) gpr_bus_i (
		.clk,
		.arst_n,
		.flush,
		.req      (gpr_req),
		.ready    (gpr_ready),
		.in_req   (gpr_in_req),
		.in_ready (gpr_in_ready),
		.result   (gpr_result),
		.bus      (gpr_bus)
	);

	operand_merge #(.N_READ(N_READ)) gpr_merge (
		.arch_read (gpr_arch_read),
		.rob_read  (gpr_rob_read),
		.bus       (gpr_bus),
		.operand   (gpr_operand)
	);

	////////////////////////////////////////////////////////////
	// fpr
	////////////////////////////////////////////////////////////

	result_bus #(
		.DEPTH  (unit_pkg::FPR_DEPTH),
		.N_REQ  (unit_pkg::FPR_N_UNIT),
		.STAGE  (unit_pkg::FPR_STAGE),
		.unit_t (unit_pkg::fpr_unit_t)
	) fpr_bus_i (
		.clk,
		.arst_n,
		.flush,
		.req      (fpr_req),
		.ready    (fpr_ready),
		.in_req   (fpr_in_req),
		.in_ready (fpr_in_ready),
		.result   (fpr_result),
		.bus      (fpr_bus)
	);

	operand_merge #(.N_READ(N_READ)) fpr_merge (
		.arch_read (fpr_arch_read),
		.rob_read  (fpr_rob_read),
		.bus       (fpr_bus),
		.operand   (fpr_operand)
	);

endmodule

// ==== bench/cdb_sva.sv ====
`timescale 1ns/1ps

module cdb_sva (
	input logic                            clk,
	input logic                            arst_n,
	input logic                            flush,
	input bus_pkg::slot_req_t              gpr_req [unit_pkg::GPR_N_UNIT],
	input logic [unit_pkg::GPR_N_UNIT-1:0] gpr_ready,
	input bus_pkg::slot_req_t              fpr_req [unit_pkg::FPR_N_UNIT],
	input logic [unit_pkg::FPR_N_UNIT-1:0] fpr_ready,
	input bus_pkg::in_req_t                gpr_in_req,
	input bus_pkg::in_req_t                fpr_in_req,
	input logic                            gpr_in_ready,
	input logic                            fpr_in_ready,
	input bus_pkg::cdb_t                   gpr_bus,
	input bus_pkg::cdb_t                   fpr_bus
);

	int   fail_count = 0;
	logic gpr_head_grant;
	logic fpr_head_grant;

	// a grant at the head stage owns the next beat
	always_comb begin
		gpr_head_grant = 1'b0;
		fpr_head_grant = 1'b0;
		for (int i = 0; i < unit_pkg::GPR_N_UNIT; i++) begin
			if (unit_pkg::GPR_STAGE[i] == 0 && gpr_req[i].valid && gpr_ready[i]) begin
				gpr_head_grant = 1'b1;
			end
		end
		for (int i = 0; i < unit_pkg::FPR_N_UNIT; i++) begin
			if (unit_pkg::FPR_STAGE[i] == 0 && fpr_req[i].valid && fpr_ready[i]) begin
				fpr_head_grant = 1'b1;
			end
		end
	end

	// nothing reserved survives a flush
	flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> gpr_bus.valid == gpr_in_req.valid && fpr_bus.valid == fpr_in_req.valid)
		else begin
			fail_count++;
			$error("reservation reached a bus right after flush");
		end

	// fdiv enters at the deepest stage
	fdiv_latency: assert property (@(posedge clk) disable iff (!arst_n)
		(fpr_req[0].valid && fpr_ready[0] && !flush) ##1 (!flush) [*13]
		|=> fpr_bus.valid && fpr_bus.tag == $past(fpr_req[0].tag, 14))
		else begin
			fail_count++;
			$error("fdiv tag missing from fpr bus 14 cycles after grant");
		end

	in_path_free: assert property (@(posedge clk) disable iff (!arst_n)
		!flush |=> (!$past(gpr_head_grant) || (!gpr_in_ready && gpr_bus.valid)) &&
			(!$past(fpr_head_grant) || (!fpr_in_ready && fpr_bus.valid)))
		else begin
			fail_count++;
			$error("input path ready while a reservation drives the bus");
		end

endmodule

bind cdb_top cdb_sva bus_checks (.*);

// ==== bench/cdb_tb.sv ====
`timescale 1ns/1ps

module cdb_tb;

	localparam int NG = unit_pkg::GPR_N_UNIT;
	localparam int NF = unit_pkg::FPR_N_UNIT;

	logic               clk = 1'b0;
	logic               arst_n;
	logic               flush;
	bus_pkg::slot_req_t gpr_req [NG];
	bus_pkg::slot_req_t fpr_req [NF];
	logic [NG-1:0]      gpr_ready;
	logic [NF-1:0]      fpr_ready;
	bus_pkg::in_req_t   gpr_in_req;
	bus_pkg::in_req_t   fpr_in_req;
	logic               gpr_in_ready;
	logic               fpr_in_ready;
	bus_pkg::word_t     gpr_result [NG];
	bus_pkg::word_t     fpr_result [NF];
	bus_pkg::cdb_t      gpr_bus;
	bus_pkg::cdb_t      fpr_bus;
	bus_pkg::cdb_t      gpr_arch_read [2];
	bus_pkg::cdb_t      fpr_arch_read [2];
	bus_pkg::rob_read_t gpr_rob_read [2];
	bus_pkg::rob_read_t fpr_rob_read [2];
	bus_pkg::cdb_t      gpr_operand [2];
	bus_pkg::cdb_t      fpr_operand [2];

	// model state per bus (0 gpr, 1 fpr) and per cycles to the bus
	logic               occ      [2][unit_pkg::FPR_DEPTH];
	bus_pkg::tag_t      occ_tag  [2][unit_pkg::FPR_DEPTH];
	int                 occ_unit [2][unit_pkg::FPR_DEPTH];
	bus_pkg::slot_req_t req_m    [2][NF];
	bus_pkg::word_t     res_m    [2][NF];
	bus_pkg::in_req_t   in_m     [2];
	bus_pkg::cdb_t      arch_m   [2][2];
	bus_pkg::rob_read_t rob_m    [2][2];
	logic [NF-1:0]      ready_m  [2];
	bus_pkg::cdb_t      bus_m    [2];
	integer             seed;

	cdb_top UUT (.*);

	always #20 clk = ~clk;

	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2 arst_n = 1'b1;
	end

	function automatic int stage_of(input int b, input int i);
		if (b == 0) begin
			return unit_pkg::GPR_STAGE[i];
		end
		return unit_pkg::FPR_STAGE[i];
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_ready(input string name, input logic [NF-1:0] got,
			input logic [NF-1:0] want);
		if (got !== want) begin
			stop_on_error($sformatf("ERR %s got %h want %h", name, got, want));
		end
	endtask

	// tag and data only matter on a valid beat
	task automatic check_bus(input string name, input bus_pkg::cdb_t got,
			input bus_pkg::cdb_t want);
		if (got.valid !== want.valid || (want.valid && got !== want)) begin
			stop_on_error($sformatf("ERR %s got %h want %h", name, got, want));
		end
	endtask

	task automatic check_operand(input string name, input bus_pkg::cdb_t got,
			input bus_pkg::cdb_t want);
		if (got !== want) begin
			stop_on_error($sformatf("ERR %s got %h want %h", name, got, want));
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and reference model
	////////////////////////////////////////////////////////////

	task automatic drive_inputs(input bit idle);
		flush = !idle && ($unsigned($random(seed)) % 100 == 0);
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < NF; i++) begin
				req_m[b][i] = '{valid: !idle && 1'($random(seed)),
					tag: bus_pkg::tag_t'($random(seed))};
				res_m[b][i] = $random(seed);
			end
			in_m[b] = '{valid: !idle && 1'($random(seed)),
				tag: bus_pkg::tag_t'($random(seed)), data: $random(seed)};
			for (int p = 0; p < 2; p++) begin
				arch_m[b][p] = '{valid: 2'($random(seed)) == 2'd0,
					tag: bus_pkg::tag_t'($random(seed)), data: $random(seed)};
				rob_m[b][p] = '{valid: 1'($random(seed)), data: $random(seed)};
			end
		end
		for (int i = 0; i < NF; i++) begin
			if (i < NG) begin
				gpr_req[i] = req_m[0][i];
				gpr_result[i] = res_m[0][i];
			end
			fpr_req[i] = req_m[1][i];
			fpr_result[i] = res_m[1][i];
		end
		gpr_in_req = in_m[0];
		fpr_in_req = in_m[1];
		gpr_arch_read = arch_m[0];
		fpr_arch_read = arch_m[1];
		gpr_rob_read = rob_m[0];
		fpr_rob_read = rob_m[1];
	endtask

	task automatic compute_expected();
		int  k;
		int  d;
		bit  blocked;
		for (int b = 0; b < 2; b++) begin
			d = b ? unit_pkg::FPR_DEPTH : unit_pkg::GPR_DEPTH;
			ready_m[b] = '0;
			for (int i = 0; i < (b ? NF : NG); i++) begin
				k = stage_of(b, i);
				// a beat passing through stage k+1 takes stage k next
				blocked = k + 1 < d && occ[b][k + 1];
				for (int j = 0; j < i; j++) begin
					if (stage_of(b, j) == k && req_m[b][j].valid) begin
						blocked = 1'b1;
					end
				end
				ready_m[b][i] = !blocked;
			end
			bus_m[b] = '0;
			if (occ[b][0]) begin
				bus_m[b] = '{valid: 1'b1, tag: occ_tag[b][0], data: res_m[b][occ_unit[b][0]]};
			end else if (in_m[b].valid) begin
				bus_m[b] = '{valid: 1'b1, tag: in_m[b].tag, data: in_m[b].data};
			end
		end
	endtask

	function automatic bus_pkg::cdb_t merged(input int b, input int p);
		bus_pkg::cdb_t m;
		logic          hit;
		hit = bus_m[b].valid && bus_m[b].tag == arch_m[b][p].tag;
		m.valid = arch_m[b][p].valid || rob_m[b][p].valid || hit;
		m.tag = arch_m[b][p].tag;
		m.data = arch_m[b][p].valid ? arch_m[b][p].data :
			hit ? bus_m[b].data : rob_m[b][p].data;
		return m;
	endfunction

	task automatic check_outputs();
		check_ready("gpr_ready", gpr_ready, ready_m[0]);
		check_ready("fpr_ready", fpr_ready, ready_m[1]);
		check_ready("gpr_in_ready", gpr_in_ready, !occ[0][0]);
		check_ready("fpr_in_ready", fpr_in_ready, !occ[1][0]);
		check_bus("gpr_bus", gpr_bus, bus_m[0]);
		check_bus("fpr_bus", fpr_bus, bus_m[1]);
		for (int p = 0; p < 2; p++) begin
			check_operand($sformatf("gpr_operand[%0d]", p), gpr_operand[p], merged(0, p));
			check_operand($sformatf("fpr_operand[%0d]", p), fpr_operand[p], merged(1, p));
		end
	endtask

	// grants land k+1 cycles out and a flush drops them all
	task automatic advance_model();
		int d;
		for (int b = 0; b < 2; b++) begin
			d = b ? unit_pkg::FPR_DEPTH : unit_pkg::GPR_DEPTH;
			for (int s = 0; s + 1 < d; s++) begin
				occ[b][s] = occ[b][s + 1];
				occ_tag[b][s] = occ_tag[b][s + 1];
				occ_unit[b][s] = occ_unit[b][s + 1];
			end
			occ[b][d - 1] = 1'b0;
			for (int i = 0; i < (b ? NF : NG); i++) begin
				if (req_m[b][i].valid && ready_m[b][i]) begin
					occ[b][stage_of(b, i)] = 1'b1;
					occ_tag[b][stage_of(b, i)] = req_m[b][i].tag;
					occ_unit[b][stage_of(b, i)] = i;
				end
			end
			if (flush) begin
				occ[b] = '{default: 1'b0};
			end
		end
	endtask

	initial begin
		int wait_cycles;
		seed = 32'h8322_2d52;
		occ = '{default: '{default: 1'b0}};
		drive_inputs(1'b1);
		wait_cycles = 0;
		while (arst_n !== 1'b1) begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > 20) begin
				stop_on_error("reset was not released within 20 cycles");
			end
		end
		for (int cyc = 0; cyc < 3000; cyc++) begin
			@(posedge clk);
			#2;
			// both buses stay quiet through the idle start
			drive_inputs(cyc < 4);
			#36;
			compute_expected();
			check_outputs();
			advance_model();
		end
		if (UUT.bus_checks.fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== cdb.f ====
design/bus_pkg.sv
design/unit_pkg.sv
design/slot_reserve.sv
design/result_bus.sv
design/operand_merge.sv
design/cdb_top.sv
bench/cdb_sva.sv
bench/cdb_tb.sv
